// File: Bender.yml
package:
  name: rv32i_single_cycle

sources:
  - design/rv_pkg.sv
  - design/control_unit.sv
  - design/imm_decode.sv
  - design/register_file.sv
  - design/alu.sv
  - design/pc_reg.sv
  - design/lsu.sv
  - design/cpu.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/cpu_assertions.sv
      - tests/cpu_tb.sv

// File: design/alu.sv
// alu: rv32i add/sub, shifts, set-less-than and logic ops with less and is_zero flags
`timescale 1ns/1ns

module alu (
    input  rv_pkg::alu_sel_e        alu_sel,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    less,
    output logic                    is_zero
);
    import rv_pkg::*;

    localparam int SHW = $clog2(XLEN); // 5 bit shift amount

    logic [SHW-1:0] shamt;
    logic           lt_signed;
    logic           lt_unsigned;

    assign shamt       = b[SHW-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // sltu picks the unsigned compare, everything else signed
    assign less = (alu_sel == SLTU) ? lt_unsigned : lt_signed;

    always_comb begin
        case (alu_sel)
            ADD:  result = a + b;
            SUB:  result = a - b; // also beq / bne compare
            SLL:  result = a << shamt;
            SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            XOR:  result = a ^ b;
            SRL:  result = a >> shamt;
            SRA:  result = $signed(a) >>> shamt; // sign fill
            OR:   result = a | b;
            AND:  result = a & b;
            default: begin
                result = a + b;
            end
        endcase
    end

    assign is_zero = (result == '0);

endmodule

// File: design/control_unit.sv
// control_unit: rv32i opcode / funct decode into datapath selects, enables and branch resolution
`timescale 1ns/1ns

module control_unit (
    input  rv_pkg::opcode_e   opcode,
    input  logic [2:0]        funct3,
    input  logic              funct7_b30,
    input  logic              less,      // from alu compare
    input  logic              is_zero,   // from alu result
    output rv_pkg::imm_kind_e imm_kind,
    output logic              reg_we,
    output logic              alu_a_src, // 0 rs1, 1 pc
    output logic [1:0]        alu_b_src, // rs2, imm or four
    output rv_pkg::alu_sel_e  alu_sel,
    output logic              pc_a_src,  // increment: 0 four, 1 imm
    output logic              pc_b_src,  // base: 0 pc, 1 rs1
    output logic              load,
    output logic              store,
    output rv_pkg::mem_size_e mem_size,
    output logic              load_unsigned
);
    import rv_pkg::*;

    logic br_take;

    // funct3 to alu op, sub only exists in the reg-reg form
    function automatic alu_sel_e decode_funct(input logic [2:0] f3, input logic b30,
                                              input logic reg_op);
        alu_sel_e sel;
        case (f3)
            3'b000:  sel = (reg_op && b30) ? SUB : ADD;
            3'b001:  sel = SLL;
            3'b010:  sel = SLT;
            3'b011:  sel = SLTU;
            3'b100:  sel = XOR;
            3'b101:  sel = b30 ? SRA : SRL; // srai keeps bit 30 too
            3'b110:  sel = OR;
            default: sel = AND;
        endcase
        return sel;
    endfunction

    // branch condition from the alu flags
    always_comb begin
        case (funct3)
            3'b000:         br_take = is_zero;  // beq
            3'b001:         br_take = !is_zero; // bne
            3'b100, 3'b110: br_take = less;     // blt, bltu
            3'b101, 3'b111: br_take = !less;    // bge, bgeu
            default:        br_take = 1'b0;
        endcase
    end

    always_comb begin
        imm_kind      = IMM_I; // defaults give a no-op
        reg_we        = 1'b0;
        alu_a_src     = 1'b0;
        alu_b_src     = BSRC_RS2;
        alu_sel       = ADD;
        pc_a_src      = 1'b0;
        pc_b_src      = 1'b0;
        load          = 1'b0;
        store         = 1'b0;
        mem_size      = WORD;
        load_unsigned = 1'b0;
        case (opcode)
            OP: begin
                reg_we  = 1'b1;
                alu_sel = decode_funct(funct3, funct7_b30, 1'b1);
            end
            OP_IMM: begin
                reg_we    = 1'b1;
                alu_b_src = BSRC_IMM;
                alu_sel   = decode_funct(funct3, funct7_b30, 1'b0);
            end
            LOAD, STORE: begin
                imm_kind      = (opcode == STORE) ? IMM_S : IMM_I;
                reg_we        = (opcode == LOAD);
                load          = (opcode == LOAD);
                store         = (opcode == STORE);
                alu_b_src     = BSRC_IMM; // address = rs1 + offset
                load_unsigned = funct3[2];
                case (funct3[1:0])
                    2'b00:   mem_size = BYTE;
                    2'b01:   mem_size = HALF;
                    default: mem_size = WORD;
                endcase
            end
            BRANCH: begin
                imm_kind = IMM_B;
                alu_sel  = funct3[2] ? (funct3[1] ? SLTU : SLT) : SUB;
                pc_a_src = br_take; // taken adds the offset
            end
            JAL, JALR: begin
                imm_kind  = (opcode == JAL) ? IMM_J : IMM_I;
                reg_we    = 1'b1;
                alu_a_src = 1'b1;      // link = pc + 4
                alu_b_src = BSRC_FOUR;
                pc_a_src  = 1'b1;
                pc_b_src  = (opcode == JALR);
            end
            LUI: begin
                imm_kind  = IMM_U;
                reg_we    = 1'b1;
                alu_b_src = BSRC_IMM; // x0 + imm, rs1 forced to zero in cpu
            end
            AUIPC: begin
                imm_kind  = IMM_U;
                reg_we    = 1'b1;
                alu_a_src = 1'b1;
                alu_b_src = BSRC_IMM;
            end
            default: begin
                reg_we = 1'b0; // unknown opcode, just step the pc
            end
        endcase
    end

endmodule

// File: design/cpu.sv
// cpu: single-cycle rv32i core top level, operand muxes, write-back select and data bus
`timescale 1ns/1ns

module cpu #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] cmd,        // instruction at pc
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata, // same-cycle read data
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic [rv_pkg::XLEN-1:0] dnpc,
    output logic [rv_pkg::XLEN-1:0] dmem_addr,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata,
    output logic [3:0]              dmem_wmask,
    output logic                    dmem_we,
    output logic                    dmem_re
);
    import rv_pkg::*;

    instr_u                instr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       src1, src2, imm;
    logic [XLEN-1:0]       alu_a, alu_b, alu_result;
    logic [XLEN-1:0]       load_data, wb_data;
    logic [XLEN-1:0]       pc_inc, pc_base;
    imm_kind_e             imm_kind;
    alu_sel_e              alu_sel;
    mem_size_e             mem_size;
    logic                  reg_we, load, store, load_unsigned;
    logic                  alu_a_src, pc_a_src, pc_b_src;
    logic [1:0]            alu_b_src;
    logic                  less, is_zero;

    assign instr = cmd;
    // lui adds its immediate to x0
    assign rs1_addr = (instr.reg_view.opcode == LUI) ? '0 : instr.reg_view.rs1;

    control_unit u_ctrl (
        .opcode(instr.reg_view.opcode), .funct3(instr.reg_view.funct3),
        .funct7_b30(instr.reg_view.funct7[5]), .less(less), .is_zero(is_zero),
        .imm_kind(imm_kind), .reg_we(reg_we), .alu_a_src(alu_a_src),
        .alu_b_src(alu_b_src), .alu_sel(alu_sel), .pc_a_src(pc_a_src),
        .pc_b_src(pc_b_src), .load(load), .store(store), .mem_size(mem_size),
        .load_unsigned(load_unsigned)
    );

    imm_decode u_imm (.cmd(instr), .imm_kind(imm_kind), .imm(imm));

    register_file u_rf (
        .clk(clk), .raddr_a(rs1_addr), .raddr_b(instr.reg_view.rs2),
        .waddr(instr.reg_view.rd), .wdata(wb_data), .wen(reg_we),
        .rdata_a(src1), .rdata_b(src2)
    );

    assign alu_a = alu_a_src ? pc : src1;

    always_comb begin
        case (alu_b_src)
            BSRC_RS2: alu_b = src2;
            BSRC_IMM: alu_b = imm;
            default:  alu_b = XLEN'(4); // link address
        endcase
    end

    alu u_alu (
        .alu_sel(alu_sel), .a(alu_a), .b(alu_b),
        .result(alu_result), .less(less), .is_zero(is_zero)
    );

    assign pc_inc  = pc_a_src ? imm : XLEN'(4);
    assign pc_base = pc_b_src ? src1 : pc;

    pc_reg #(.RESET_PC(RESET_PC)) u_pc (
        .clk(clk), .rst_n(rst_n), .inc(pc_inc), .base(pc_base),
        .clear_b0(pc_b_src), .pc(pc), .dnpc(dnpc) // bit 0 cleared only for jalr
    );

    lsu u_lsu (
        .addr_low(alu_result[1:0]), .store(store), .mem_size(mem_size),
        .load_unsigned(load_unsigned), .store_data(src2), .dmem_rdata(dmem_rdata),
        .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask), .dmem_we(dmem_we),
        .load_data(load_data)
    );

    assign dmem_addr = {alu_result[XLEN-1:2], 2'b00}; // lane picked by wmask
    assign dmem_re   = load;
    assign wb_data   = load ? load_data : alu_result;

endmodule

// File: design/imm_decode.sv
// imm_decode: sign-extended immediate for the I, S, B, U and J instruction formats
`timescale 1ns/1ns

module imm_decode (
    input  rv_pkg::instr_u          cmd,
    input  rv_pkg::imm_kind_e       imm_kind,
    output logic [rv_pkg::XLEN-1:0] imm
);
    import rv_pkg::*;

    imm_view_t f;
    logic      sign;

    assign f    = cmd.imm_view;
    assign sign = f.hi7[6]; // instruction bit 31 is the sign in every format

    always_comb begin
        case (imm_kind)
            IMM_I: imm = {{20{sign}}, f.hi7, f.mid5};
            IMM_S: imm = {{20{sign}}, f.hi7, f.lo5};
            // offsets in halfwords, bit 0 always zero
            IMM_B: imm = {{19{sign}}, sign, f.lo5[0], f.hi7[5:0], f.lo5[4:1], 1'b0};
            IMM_U: imm = {f.hi7, f.mid5, f.mid8, 12'b0}; // upper 20, low bits zero
            IMM_J: imm = {{11{sign}}, sign, f.mid8, f.mid5[0], f.hi7[5:0], f.mid5[4:1], 1'b0};
            default: begin
                imm = {XLEN{1'b0}};
            end
        endcase
    end

endmodule

// File: design/lsu.sv
// lsu: store lane replication and byte mask, load lane select with sign / zero extension
`timescale 1ns/1ns

module lsu (
    input  logic [1:0]              addr_low,
    input  logic                    store,
    input  rv_pkg::mem_size_e       mem_size,
    input  logic                    load_unsigned,
    input  logic [rv_pkg::XLEN-1:0] store_data,  // rs2
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata,
    output logic [3:0]              dmem_wmask,
    output logic                    dmem_we,
    output logic [rv_pkg::XLEN-1:0] load_data
);
    import rv_pkg::*;

    logic [3:0]      mask;
    logic [XLEN-1:0] rd_lane; // addressed lane moved down to bit 0
    logic            ext;

    // data copied into every lane, mask picks the live one
    always_comb begin
        case (mem_size)
            BYTE: begin
                dmem_wdata = {4{store_data[7:0]}};
                mask       = 4'b0001 << addr_low;
            end
            HALF: begin
                dmem_wdata = {2{store_data[15:0]}};
                mask       = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem_wdata = store_data;
                mask       = 4'b1111;
            end
        endcase
    end

    assign dmem_wmask = store ? mask : 4'b0000;
    assign dmem_we    = store;

    assign rd_lane = dmem_rdata >> {addr_low, 3'b000};
    assign ext     = !load_unsigned; // lbu / lhu zero fill

    always_comb begin
        case (mem_size)
            BYTE:    load_data = {{24{ext & rd_lane[7]}}, rd_lane[7:0]};
            HALF:    load_data = {{16{ext & rd_lane[15]}}, rd_lane[15:0]};
            default: load_data = dmem_rdata;
        endcase
    end

endmodule

// File: design/pc_reg.sv
// pc_reg: program counter with reset vector and next-pc adder
`timescale 1ns/1ns

module pc_reg #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] inc,      // four or branch / jump offset
    input  logic [rv_pkg::XLEN-1:0] base,     // pc or rs1
    input  logic                    clear_b0, // jalr target
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic [rv_pkg::XLEN-1:0] dnpc
);
    import rv_pkg::*;

    logic [XLEN-1:0] sum;

    assign sum  = base + inc;
    assign dnpc = clear_b0 ? {sum[XLEN-1:1], 1'b0} : sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= dnpc; // one instruction per clock
        end
    end

endmodule

// File: design/register_file.sv
// register_file: 32 x 32 integer registers, two combinational reads, one clocked write, x0 = 0
`timescale 1ns/1ns

module register_file (
    input  logic                          clk,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_b,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]       wdata,
    input  logic                          wen,
    output logic [rv_pkg::XLEN-1:0]       rdata_a,
    output logic [rv_pkg::XLEN-1:0]       rdata_b
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W]; // entry 0 never written

    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata; // writes to x0 dropped
        end
    end

    // reads see the old value until the edge
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: design/rv_pkg.sv
// rv32i shared widths, opcode / alu / immediate / access-size encodings and the instruction word union
package rv_pkg;

    localparam int XLEN       = 32; // data and address width
    localparam int REG_ADDR_W = 5;  // x0..x31

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // reg-reg alu
        OP_IMM = 7'b0010011, // reg-imm alu
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_sel_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0, // loads, jalr, alu immediates
        IMM_S = 3'd1, // stores
        IMM_B = 3'd2, // branches
        IMM_U = 3'd3, // lui, auipc
        IMM_J = 3'd4  // jal
    } imm_kind_e;

    // same coding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    // alu operand b sources
    localparam logic [1:0] BSRC_RS2  = 2'd0;
    localparam logic [1:0] BSRC_IMM  = 2'd1;
    localparam logic [1:0] BSRC_FOUR = 2'd2; // link value pc+4

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } reg_view_t;

    // slices that the immediate formats are assembled from
    typedef struct packed {
        logic [6:0] hi7;  // [31:25]
        logic [4:0] mid5; // [24:20]
        logic [7:0] mid8; // [19:12]
        logic [4:0] lo5;  // [11:7]
        logic [6:0] op;   // [6:0]
    } imm_view_t;

    typedef union packed {
        reg_view_t reg_view;
        imm_view_t imm_view;
    } instr_u;

endpackage

// File: src.f
design/rv_pkg.sv
design/control_unit.sv
design/imm_decode.sv
design/register_file.sv
design/alu.sv
design/pc_reg.sv
design/lsu.sv
design/cpu.sv
tests/clock_gen.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

// File: tests/clock_gen.sv
// clock_gen: free-running testbench clock and synchronous active-low reset
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 4,  // ns
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released on a falling edge, first fetch follows
    end

endmodule

// File: tests/cpu_assertions.sv
// cpu_assertions: bound checks on data bus strobes, store byte mask and reset vector
`timescale 1ns/1ns

module cpu_assertions #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic [rv_pkg::XLEN-1:0] pc,
    input logic                    dmem_we,
    input logic                    dmem_re,
    input logic [3:0]              dmem_wmask
);

    int fail_count = 0; // failures so far

    // one instruction is a load or a store, never both
    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_we && dmem_re))
    else begin
        fail_count++;
        $error("dmem_we and dmem_re are high in the same cycle");
    end

    // first cycle out of reset fetches from the reset vector
    reset_vector: assert property (@(posedge clk) $rose(rst_n) |-> pc == RESET_PC)
    else begin
        fail_count++;
        $error("pc is not the reset vector after reset release");
    end

    store_has_mask: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> dmem_wmask != 4'b0000)
    else begin
        fail_count++;
        $error("store strobe with an empty byte mask");
    end

endmodule

bind cpu cpu_assertions #(.RESET_PC(RESET_PC)) cpu_assertions_inst (
    .clk(clk), .rst_n(rst_n), .pc(pc), .dmem_we(dmem_we), .dmem_re(dmem_re),
    .dmem_wmask(dmem_wmask)
);

// File: tests/cpu_tb.sv
// cpu_tb: instruction table with expected pc / dnpc / stores, data memory model, timeout
`timescale 1ns/1ns

module cpu_tb;

    localparam logic [31:0] RESET_PC  = 32'h8000_0000;
    localparam logic [6:0]  OPC_IMM   = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD  = 7'b0000011;
    localparam logic [6:0]  OPC_LUI   = 7'b0110111;
    localparam logic [6:0]  OPC_AUIPC = 7'b0010111;
    localparam logic [6:0]  OPC_JALR  = 7'b1100111;

    logic        clk, rst_n;
    logic [31:0] cmd, dmem_rdata, pc, dnpc, dmem_addr, dmem_wdata;
    logic [3:0]  dmem_wmask;
    logic        dmem_we, dmem_re;

    logic [31:0] mem [256];  // word addressed by dmem_addr[9:2]
    logic [31:0] xr [32];    // expected register contents
    logic [31:0] cur_pc;     // expected pc while the table is built
    logic [31:0] tab_cmd[$], tab_pc[$], tab_dnpc[$], tab_addr[$], tab_data[$];
    logic [3:0]  tab_mask[$];
    logic        tab_st[$];  // entry expects a store
    logic        tab_ld[$];  // entry expects a read strobe
    logic [31:0] lane;
    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;

    clock_gen #(.PERIOD(4), .RESET_CYCLES(16)) clock_gen_inst (.clk(clk), .rst_n(rst_n));

    cpu #(.RESET_PC(RESET_PC)) cpu_inst (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .dmem_rdata(dmem_rdata), .pc(pc),
        .dnpc(dnpc), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wmask(dmem_wmask), .dmem_we(dmem_we), .dmem_re(dmem_re)
    );

    assign dmem_rdata = mem[dmem_addr[9:2]]; // same-cycle read

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask[b]) begin
                    mem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got,
                     expected);
        end
    endtask

    // every byte depends on the full word index
    function automatic logic [31:0] mem_pattern(input logic [7:0] i);
        return {i ^ 8'ha5, i, ~i, i + 8'h81};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011}; // base always x0
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // rv32i integer op by funct3 and instruction bit 30 (alt)
    function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'h0, $signed(a) < $signed(b)};
            3'd3: return {31'h0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                else return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic table_entry(input logic [31:0] instr, input logic [31:0] next_pc,
                               input logic st, input logic [31:0] addr,
                               input logic [31:0] data, input logic [3:0] mask);
        tab_cmd.push_back(instr);
        tab_pc.push_back(cur_pc);
        tab_dnpc.push_back(next_pc);
        tab_st.push_back(st);
        tab_ld.push_back(instr[6:0] == OPC_LOAD);
        tab_addr.push_back(addr);
        tab_data.push_back(data);
        tab_mask.push_back(mask);
        cur_pc = next_pc;
    endtask

    task automatic next_instr(input logic [31:0] instr);
        table_entry(instr, cur_pc + 32'd4, 1'b0, 32'd0, 32'd0, 4'b0000);
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] instr,
                             input logic [31:0] value);
        next_instr(instr);
        if (rd != 5'd0) xr[rd] = value;
    endtask

    // lui + addi with the upper part rounded for a negative low 12 bits
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + {20'h0, value[11], 11'h0};
        write_reg(rd, {upper[31:12], rd, OPC_LUI}, {upper[31:12], 12'h000});
        write_reg(rd, i_type(value[11:0], rd, 3'b000, rd, OPC_IMM), value);
    endtask

    task automatic store_reg(input logic [4:0] rs);
        table_entry(s_type(12'd64, rs, 3'b010), cur_pc + 32'd4, 1'b1, 32'd64, xr[rs], 4'hf);
    endtask

    task automatic jump_link(input logic [4:0] rd, input logic [31:0] instr,
                             input logic [31:0] target);
        xr[rd] = cur_pc + 32'd4; // link
        table_entry(instr, target, 1'b0, 32'd0, 32'd0, 4'b0000);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] w;
        logic [11:0] imm12;
        logic [12:0] off;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [2:0]  f3;
        logic        alt;
        next_instr(32'h0000_0000); // opcode 0 only steps the pc
        next_instr(32'h0000_0000);
        load_reg(5'd1, $random(seed) | 32'h8000_0000); // negative for sra
        load_reg(5'd2, $random(seed));
        for (int k = 0; k < 10; k++) begin // reg-reg ops with sub and sra last
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = (k >= 8);
            write_reg(5'd3, r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3),
                      expected_alu(f3, alt, xr[1], xr[2]));
            store_reg(5'd3);
        end
        for (int k = 0; k < 9; k++) begin // reg-imm ops with srai last
            f3    = (k < 8) ? 3'(k) : 3'd5;
            alt   = (k == 8);
            rnd   = $random(seed);
            imm12 = (f3[1:0] == 2'b01) ? {alt ? 7'h20 : 7'h00, rnd[4:0]} : rnd[11:0];
            write_reg(5'd3, i_type(imm12, 5'd1, f3, 5'd3, OPC_IMM),
                      expected_alu(f3, alt, xr[1], {{20{imm12[11]}}, imm12}));
            store_reg(5'd3);
        end
        rnd = $random(seed);
        write_reg(5'd4, {rnd[19:0], 5'd4, OPC_LUI}, {rnd[19:0], 12'h000});
        store_reg(5'd4);
        write_reg(5'd5, {rnd[31:12], 5'd5, OPC_AUIPC}, cur_pc + {rnd[31:12], 12'h000});
        store_reg(5'd5);
        jump_link(5'd6, j_type(21'd12, 5'd6), cur_pc + 32'd12);
        store_reg(5'd6);
        load_reg(5'd9, 32'h8000_1000);
        jump_link(5'd7, i_type(12'd13, 5'd9, 3'b000, 5'd7, OPC_JALR),
                  (xr[9] + 32'd13) & ~32'd1); // odd sum loses bit 0
        store_reg(5'd7);
        for (int p = 0; p < 3; p++) begin // operand pairs (1,2) (2,1) (1,1)
            s1  = (p == 1) ? 5'd2 : 5'd1;
            s2  = (p == 0) ? 5'd2 : 5'd1;
            off = (p == 1) ? -13'sd12 : 13'd16; // backward on the middle pass
            for (int k = 0; k < 6; k++) begin
                f3 = (k < 2) ? 3'(k) : 3'(k + 2);
                table_entry(b_type(off, s2, s1, f3),
                            branch_taken(f3, xr[s1], xr[s2]) ?
                                cur_pc + {{19{off[12]}}, off} : cur_pc + 32'd4,
                            1'b0, 32'd0, 32'd0, 4'b0000);
            end
        end
        table_entry(s_type(12'd65, 5'd2, 3'b000), cur_pc + 32'd4, 1'b1, 32'd64,
                    {16'h0, xr[2][7:0], 8'h0}, 4'b0010); // sb lane 1
        table_entry(s_type(12'd67, 5'd1, 3'b000), cur_pc + 32'd4, 1'b1, 32'd64,
                    {xr[1][7:0], 24'h0}, 4'b1000);
        table_entry(s_type(12'd66, 5'd2, 3'b001), cur_pc + 32'd4, 1'b1, 32'd64,
                    {xr[2][15:0], 16'h0}, 4'b1100); // sh upper half
        w = mem_pattern(8'd32); // word at 128 is never stored to
        write_reg(5'd10, i_type(12'd129, 5'd0, 3'b000, 5'd10, OPC_LOAD), {{24{w[15]}}, w[15:8]});
        store_reg(5'd10);
        write_reg(5'd11, i_type(12'd131, 5'd0, 3'b100, 5'd11, OPC_LOAD), {24'h0, w[31:24]});
        store_reg(5'd11);
        write_reg(5'd12, i_type(12'd130, 5'd0, 3'b001, 5'd12, OPC_LOAD), {{16{w[31]}}, w[31:16]});
        store_reg(5'd12);
        write_reg(5'd13, i_type(12'd130, 5'd0, 3'b101, 5'd13, OPC_LOAD), {16'h0, w[31:16]});
        store_reg(5'd13);
        write_reg(5'd14, i_type(12'd128, 5'd0, 3'b010, 5'd14, OPC_LOAD), w);
        store_reg(5'd14);
        next_instr(i_type(12'd123, 5'd0, 3'b000, 5'd0, OPC_IMM)); // addi x0 is lost
        store_reg(5'd0);
    endtask

    initial begin
        cmd  = 32'h0; // no-op through reset
        seed = 32'h5f50;
        for (int i = 0; i < 256; i++) mem[i] = mem_pattern(8'(i));
        for (int i = 0; i < 32; i++) xr[i] = 32'h0;
        cur_pc = RESET_PC;
        build_table();
        cycle_limit = tab_cmd.size() + 16 + 20;
        @(posedge rst_n);
        for (int i = 0; i < tab_cmd.size(); i++) begin
            if (i > 0) @(negedge clk);
            cmd = tab_cmd[i];
            #1; // settled well before the next rising edge
            check_value("pc", pc, tab_pc[i]);
            check_value("dnpc", dnpc, tab_dnpc[i]);
            check_value("dmem_we", 32'(dmem_we), 32'(tab_st[i]));
            check_value("dmem_re", 32'(dmem_re), 32'(tab_ld[i]));
            if (tab_st[i]) begin
                for (int b = 0; b < 4; b++) lane[8*b +: 8] = {8{tab_mask[i][b]}};
                check_value("dmem_addr", dmem_addr, tab_addr[i]);
                check_value("dmem_wmask", 32'(dmem_wmask), 32'(tab_mask[i]));
                check_value("dmem_wdata", dmem_wdata & lane, tab_data[i] & lane);
            end
        end
        @(negedge clk); // last instruction retires
        cmd = 32'h0;
        errors += cpu_inst.cpu_assertions_inst.fail_count;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
